//--- Bender.yml
package:
  name: bp

sources:
  - design/bp_pkg.sv
  - design/bp_decode.sv
  - design/bp_history.sv
  - design/bp_counter_tables.sv
  - design/bp_btb.sv
  - design/bp_select.sv
  - design/bp_top.sv
  - target: simulation
    files:
      - sim/bp_props.sv
      - sim/bp_tb.sv

//--- design/bp_btb.sv
// Direct-mapped BTB with no replacement policy where each resolution overwrites its slot
`timescale 1ns/1ps

module bp_btb (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          stall_i,
  input  bp_pkg::addr_t pc_i,
  input  bp_pkg::addr_t ex_pc_i,
  input  bp_pkg::addr_t ex_target_i,
  input  logic          ex_valid_i,
  output logic          btb_hit_o,
  output bp_pkg::addr_t btb_target_o
);

  import bp_pkg::*;

  // ========================================
  // Entry storage
  // ========================================

  logic     valid_q  [BTB_ENTRIES];
  btb_tag_t tag_q    [BTB_ENTRIES];
  addr_t    target_q [BTB_ENTRIES];

  btb_idx_t rd_idx;
  btb_tag_t rd_tag;
  btb_idx_t wr_idx;
  btb_tag_t wr_tag;

  // Index from pc bits 6:1 and tag from bits 31:8
  assign rd_idx = pc_i[BTB_IDX_W:1];
  assign rd_tag = pc_i[XLEN-1:BTB_IDX_W+2];
  assign wr_idx = ex_pc_i[BTB_IDX_W:1];
  assign wr_tag = ex_pc_i[XLEN-1:BTB_IDX_W+2];

  // ========================================
  // Lookup
  // ========================================

  assign btb_hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign btb_target_o = target_q[rd_idx];

  // ========================================
  // Allocation
  // ========================================

  // Valid bit per entry
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < BTB_ENTRIES; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (!stall_i && ex_valid_i) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // The resolved target replaces the old occupant whether taken or not
  always_ff @(posedge clk_i) begin
    if (!stall_i && ex_valid_i) begin
      tag_q[wr_idx]    <= wr_tag;
      target_q[wr_idx] <= ex_target_i;
    end
  end

endmodule

//--- design/bp_counter_tables.sv
// Writes land at the edge after ex_valid_i and a lookup in the next cycle sees them
`timescale 1ns/1ps

module bp_counter_tables (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          stall_i,
  input  bp_pkg::addr_t pc_i,
  input  bp_pkg::addr_t ex_pc_i,
  input  bp_pkg::ghr_t  spec_ghr_i,
  input  bp_pkg::ghr_t  commit_ghr_i,
  input  logic          ex_valid_i,
  input  logic          ex_taken_i,
  output logic          final_taken_o
);

  import bp_pkg::*;

  // ========================================
  // Storage
  // ========================================

  ctr_t gshare_q  [PHT_ENTRIES];
  ctr_t bimodal_q [PHT_ENTRIES];

  // Upper bit set selects gshare and clear selects bimodal
  ctr_t choice_q  [PHT_ENTRIES];

  // Read side indexed by the fetch pc
  pht_idx_t gsh_rd_idx;
  pht_idx_t bim_rd_idx;
  ctr_t     gsh_rd_ctr;
  ctr_t     bim_rd_ctr;
  ctr_t     cho_rd_ctr;

  // Write side indexed by the resolved pc
  pht_idx_t gsh_wr_idx;
  pht_idx_t bim_wr_idx;
  ctr_t     gsh_wr_ctr;
  ctr_t     bim_wr_ctr;
  logic     tables_disagree;
  logic     gshare_right;

  // Saturating step toward taken or not taken
  function automatic ctr_t ctr_step(input ctr_t ctr, input logic up);
    ctr_t nxt;
    nxt = ctr;
    if (up && (ctr != CTR_MAX)) begin
      nxt = ctr + 2'd1;
    end else if (!up && (ctr != 2'd0)) begin
      nxt = ctr - 2'd1;
    end
    return nxt;
  endfunction

  // ========================================
  // Lookup
  // ========================================

  // Gshare hashes the pc with the speculative history
  assign gsh_rd_idx = pc_i[PHT_IDX_W:1] ^ spec_ghr_i;
  // Bimodal and choice see the pc alone
  assign bim_rd_idx = pc_i[PHT_IDX_W:1];

  assign gsh_rd_ctr = gshare_q[gsh_rd_idx];
  assign bim_rd_ctr = bimodal_q[bim_rd_idx];
  assign cho_rd_ctr = choice_q[bim_rd_idx];

  // Tournament pick on the counter upper bits
  assign final_taken_o = cho_rd_ctr[1] ? gsh_rd_ctr[1] : bim_rd_ctr[1];

  // ========================================
  // Training
  // ========================================

  // Same hash as lookup but with the committed history
  assign gsh_wr_idx = ex_pc_i[PHT_IDX_W:1] ^ commit_ghr_i;
  assign bim_wr_idx = ex_pc_i[PHT_IDX_W:1];

  // Counter values before this update
  assign gsh_wr_ctr = gshare_q[gsh_wr_idx];
  assign bim_wr_ctr = bimodal_q[bim_wr_idx];

  // Choice learns only when the two tables predicted differently
  assign tables_disagree = gsh_wr_ctr[1] != bim_wr_ctr[1];
  assign gshare_right    = gsh_wr_ctr[1] == ex_taken_i;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      // Every counter starts weakly taken
      for (int i = 0; i < PHT_ENTRIES; i++) begin
        gshare_q[i]  <= CTR_INIT;
        bimodal_q[i] <= CTR_INIT;
        choice_q[i]  <= CTR_INIT;
      end
    end else if (!stall_i && ex_valid_i) begin
      gshare_q[gsh_wr_idx]  <= ctr_step(gsh_wr_ctr, ex_taken_i);
      bimodal_q[bim_wr_idx] <= ctr_step(bim_wr_ctr, ex_taken_i);
      if (tables_disagree) begin
        // Up toward gshare and down toward bimodal
        choice_q[bim_wr_idx] <= ctr_step(choice_q[bim_wr_idx], gshare_right);
      end
    end
  end

endmodule

//--- design/bp_decode.sv
// Only conditional branches and JAL are recognized, JALR and compressed forms count as others
`timescale 1ns/1ps

module bp_decode (
  input  bp_pkg::inst_t inst_i,
  output logic          is_branch_o,
  output logic          is_jal_o,
  output bp_pkg::addr_t imm_o
);

  import bp_pkg::*;

  // Opcode field of the fetched word
  logic [6:0] opcode;

  // Both immediate forms, built in parallel
  addr_t      imm_b;
  addr_t      imm_j;

  assign opcode = inst_i[6:0];

  // ========================================
  // Instruction class
  // ========================================

  assign is_branch_o = (opcode == OP_BRANCH);
  assign is_jal_o    = (opcode == OP_JAL);

  // ========================================
  // Immediate extraction
  // ========================================

  // B-type, offset in multiples of two bytes
  assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

  // J-type, 21-bit signed offset
  assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  always_comb begin
    // Zero unless the word is a branch or a JAL
    imm_o = '0;
    if (is_branch_o) begin
      imm_o = imm_b;
    end else if (is_jal_o) begin
      imm_o = imm_j;
    end
  end

endmodule

//--- design/bp_history.sv
// Holds one speculative and one committed history and assumes resolutions arrive in order
`timescale 1ns/1ps

module bp_history (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         stall_i,
  input  logic         fetch_valid_i,
  input  logic         is_branch_i,
  input  logic         pred_taken_i,
  input  logic         ex_valid_i,
  input  logic         ex_taken_i,
  input  logic         ex_mispredict_i,
  output bp_pkg::ghr_t spec_ghr_o,
  output bp_pkg::ghr_t commit_ghr_o
);

  import bp_pkg::*;

  ghr_t spec_ghr_q;
  ghr_t commit_ghr_q;

  // Shifted candidates for the next state
  ghr_t commit_shift;
  ghr_t spec_shift;

  assign commit_shift = {commit_ghr_q[GHR_LEN-2:0], ex_taken_i};
  assign spec_shift   = {spec_ghr_q[GHR_LEN-2:0], pred_taken_i};

  // ========================================
  // Committed history
  // ========================================

  // Follows resolved outcomes only
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      commit_ghr_q <= '0;
    end else if (!stall_i && ex_valid_i) begin
      commit_ghr_q <= commit_shift;
    end
  end

  // ========================================
  // Speculative history
  // ========================================

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      spec_ghr_q <= '0;
    end else if (!stall_i) begin
      // Recovery wins over a branch fetched in the same cycle
      if (ex_valid_i && ex_mispredict_i) begin
        spec_ghr_q <= commit_shift;
      end else if (fetch_valid_i && is_branch_i) begin
        spec_ghr_q <= spec_shift;
      end
    end
  end

  assign spec_ghr_o   = spec_ghr_q;
  assign commit_ghr_o = commit_ghr_q;

endmodule

//--- design/bp_pkg.sv
// Sizes are fixed at compile time and GHR_LEN has to equal PHT_IDX_W for the gshare index
package bp_pkg;

  // ========================================
  // Widths and table sizes
  // ========================================

  // Address and instruction width
  localparam int unsigned XLEN        = 32;

  // Global history length, same as the counter table index
  localparam int unsigned GHR_LEN     = 8;

  // Gshare, bimodal and choice tables share one geometry
  localparam int unsigned PHT_ENTRIES = 256;
  localparam int unsigned PHT_IDX_W   = 8;

  // Direct-mapped BTB
  localparam int unsigned BTB_ENTRIES = 64;
  localparam int unsigned BTB_IDX_W   = 6;
  localparam int unsigned BTB_TAG_W   = XLEN - BTB_IDX_W - 2;

  // ========================================
  // Opcodes and counter constants
  // ========================================

  // RV32I opcodes for conditional branches and JAL
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;

  // Counters start weakly taken
  localparam logic [1:0] CTR_INIT  = 2'b10;
  localparam logic [1:0] CTR_MAX   = 2'b11;

  // ========================================
  // Shared types
  // ========================================

  typedef logic [XLEN-1:0]      addr_t;
  typedef logic [XLEN-1:0]      inst_t;
  typedef logic [1:0]           ctr_t;
  typedef logic [GHR_LEN-1:0]   ghr_t;
  typedef logic [PHT_IDX_W-1:0] pht_idx_t;
  typedef logic [BTB_IDX_W-1:0] btb_idx_t;
  typedef logic [BTB_TAG_W-1:0] btb_tag_t;

  // Kind of control transfer reported with each prediction
  typedef enum logic [1:0] {
    KIND_NONE   = 2'd0,
    KIND_JUMP   = 2'd1,
    KIND_BRANCH = 2'd2
  } bp_kind_e;

endpackage

//--- design/bp_select.sv
// Purely combinational next-pc choice, JALR and all other words fall through to pc plus 4
`timescale 1ns/1ps

module bp_select (
  input  logic             fetch_valid_i,
  input  logic             stall_i,
  input  logic             is_branch_i,
  input  logic             is_jal_i,
  input  logic             final_taken_i,
  input  logic             btb_hit_i,
  input  bp_pkg::addr_t    pc_i,
  input  bp_pkg::addr_t    imm_i,
  input  bp_pkg::addr_t    btb_target_i,
  output logic             pred_valid_o,
  output logic             pred_taken_o,
  output bp_pkg::addr_t    pred_pc_o,
  output bp_pkg::bp_kind_e pred_kind_o
);

  import bp_pkg::*;

  // Sequential and pc-relative candidates
  addr_t seq_pc;
  addr_t rel_pc;

  assign seq_pc = pc_i + XLEN'(4);
  assign rel_pc = pc_i + imm_i;

  // ========================================
  // Priority selection
  // ========================================

  always_comb begin
    pred_valid_o = 1'b0;
    pred_taken_o = 1'b0;
    pred_pc_o    = seq_pc;
    pred_kind_o  = KIND_NONE;
    if (fetch_valid_i && !stall_i) begin
      pred_valid_o = 1'b1;
      if (is_jal_i) begin
        pred_taken_o = 1'b1;
        pred_pc_o    = rel_pc;
        pred_kind_o  = KIND_JUMP;
      end else if (is_branch_i) begin
        pred_kind_o = KIND_BRANCH;
        if (btb_hit_i) begin
          // Tournament decides, target comes from the BTB
          pred_taken_o = final_taken_i;
          pred_pc_o    = final_taken_i ? btb_target_i : seq_pc;
        end else if (imm_i[XLEN-1]) begin
          // Backward taken on a BTB miss
          pred_taken_o = 1'b1;
          pred_pc_o    = rel_pc;
        end
      end
    end
  end

endmodule

//--- design/bp_top.sv
// Outputs follow pc_i and inst_i combinationally and stall_i freezes every register
`timescale 1ns/1ps

module bp_top (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             fetch_valid_i,
  input  logic             stall_i,
  input  bp_pkg::addr_t    pc_i,
  input  bp_pkg::inst_t    inst_i,
  input  logic             ex_valid_i,
  input  bp_pkg::addr_t    ex_pc_i,
  input  bp_pkg::addr_t    ex_target_i,
  input  logic             ex_taken_i,
  input  logic             ex_mispredict_i,
  output logic             pred_valid_o,
  output logic             pred_taken_o,
  output bp_pkg::addr_t    pred_pc_o,
  output bp_pkg::bp_kind_e pred_kind_o
);

  import bp_pkg::*;

  // Decode results
  logic  is_branch;
  logic  is_jal;
  addr_t imm;

  // Histories
  ghr_t  spec_ghr;
  ghr_t  commit_ghr;

  // Table and BTB lookups
  logic  final_taken;
  logic  btb_hit;
  addr_t btb_target;

  // ========================================
  // Instances
  // ========================================

  bp_decode i_bp_decode (
    .inst_i      (inst_i),
    .is_branch_o (is_branch),
    .is_jal_o    (is_jal),
    .imm_o       (imm)
  );

  // Prediction feeds back into the speculative history
  bp_history i_bp_history (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .stall_i         (stall_i),
    .fetch_valid_i   (fetch_valid_i),
    .is_branch_i     (is_branch),
    .pred_taken_i    (pred_taken_o),
    .ex_valid_i      (ex_valid_i),
    .ex_taken_i      (ex_taken_i),
    .ex_mispredict_i (ex_mispredict_i),
    .spec_ghr_o      (spec_ghr),
    .commit_ghr_o    (commit_ghr)
  );

  bp_counter_tables i_bp_counter_tables (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .stall_i       (stall_i),
    .pc_i          (pc_i),
    .ex_pc_i       (ex_pc_i),
    .spec_ghr_i    (spec_ghr),
    .commit_ghr_i  (commit_ghr),
    .ex_valid_i    (ex_valid_i),
    .ex_taken_i    (ex_taken_i),
    .final_taken_o (final_taken)
  );

  bp_btb i_bp_btb (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .stall_i      (stall_i),
    .pc_i         (pc_i),
    .ex_pc_i      (ex_pc_i),
    .ex_target_i  (ex_target_i),
    .ex_valid_i   (ex_valid_i),
    .btb_hit_o    (btb_hit),
    .btb_target_o (btb_target)
  );

  bp_select i_bp_select (
    .fetch_valid_i (fetch_valid_i),
    .stall_i       (stall_i),
    .is_branch_i   (is_branch),
    .is_jal_i      (is_jal),
    .final_taken_i (final_taken),
    .btb_hit_i     (btb_hit),
    .pc_i          (pc_i),
    .imm_i         (imm),
    .btb_target_i  (btb_target),
    .pred_valid_o  (pred_valid_o),
    .pred_taken_o  (pred_taken_o),
    .pred_pc_o     (pred_pc_o),
    .pred_kind_o   (pred_kind_o)
  );

endmodule

//--- list.f
design/bp_pkg.sv
design/bp_decode.sv
design/bp_history.sv
design/bp_counter_tables.sv
design/bp_btb.sv
design/bp_select.sv
design/bp_top.sv
sim/bp_props.sv
sim/bp_tb.sv

//--- sim/bp_props.sv
// Sampled at the rising edge of clk_i and disabled while rst_ni is low
`timescale 1ns/1ps

module bp_props (
  input logic             clk_i,
  input logic             rst_ni,
  input logic             fetch_valid_i,
  input logic             stall_i,
  input logic             pred_valid_o,
  input logic             pred_taken_o,
  input bp_pkg::bp_kind_e pred_kind_o
);

  import bp_pkg::*;

  // Assertion failures so far
  int unsigned fail_count = 0;

  // ========================================
  // Prediction output rules
  // ========================================

  // Valid only on an unstalled fetch
  valid_needs_fetch: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pred_valid_o |-> (fetch_valid_i && !stall_i))
    else begin
      fail_count++;
      $error("pred_valid_o high without an unstalled fetch");
    end

  taken_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pred_taken_o |-> pred_valid_o)
    else begin
      fail_count++;
      $error("pred_taken_o high while pred_valid_o is low");
    end

  // Plain instructions never redirect
  none_not_taken: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pred_kind_o == KIND_NONE) |-> !pred_taken_o)
    else begin
      fail_count++;
      $error("pred_taken_o high with KIND_NONE");
    end

endmodule

bind bp_top bp_props i_bp_props (.*);

//--- sim/bp_tb.sv
// Random traffic repeats exactly from seed 95 and resolutions are returned in fetch order
`timescale 1ns/1ps

module bp_tb;

  import bp_pkg::*;

  // ========================================
  // Run length, clock and DUT signals
  // ========================================

  localparam int CLK_PERIOD    = 100;
  localparam int RAND_CYCLES   = 3000;
  localparam int DIRECT_CYCLES = 40;
  localparam int MARGIN_CYCLES = 200;

  logic     clk_i;
  logic     rst_ni;
  logic     fetch_valid_i;
  logic     stall_i;
  addr_t    pc_i;
  inst_t    inst_i;
  logic     ex_valid_i;
  addr_t    ex_pc_i;
  addr_t    ex_target_i;
  logic     ex_taken_i;
  logic     ex_mispredict_i;
  logic     pred_valid_o;
  logic     pred_taken_o;
  addr_t    pred_pc_o;
  bp_kind_e pred_kind_o;

  int          check_count;
  int          error_count;
  int          test_errors;
  int          mispredicts;
  logic [15:0] lfsr_q;

  // Reference model state
  logic [1:0] m_gsh [PHT_ENTRIES];
  logic [1:0] m_bim [PHT_ENTRIES];
  logic [1:0] m_cho [PHT_ENTRIES];
  logic       m_btb_valid [BTB_ENTRIES];
  btb_tag_t   m_btb_tag [BTB_ENTRIES];
  addr_t      m_btb_tgt [BTB_ENTRIES];
  ghr_t       m_spec;
  ghr_t       m_commit;

  // Model outputs of the current cycle
  logic       m_valid;
  logic       m_taken;
  logic       m_is_branch;
  addr_t      m_pc;
  addr_t      m_imm;
  bp_kind_e   m_kind;

  // Branches fetched but not yet resolved with the oldest first
  addr_t      fl_pc [$];
  addr_t      fl_tgt [$];
  logic       fl_pred [$];

  bp_top i_bp_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Watchdog sized from the test lengths
  initial begin
    #((DIRECT_CYCLES + RAND_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("Timeout: the run did not reach its end within the expected number of cycles");
    $display("Checks failed");
    $finish;
  end

  // ========================================
  // Random numbers and checking
  // ========================================

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_step(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic end_test(input string name);
    $display("test %s finished with %0d errors", name, error_count - test_errors);
    test_errors = error_count;
  endtask

  // ========================================
  // Reference model
  // ========================================

  // Two-bit counter that sticks at 0 and 3
  function automatic logic [1:0] sat_move(input logic [1:0] c, input logic up);
    if (up) begin
      return (c == 2'd3) ? c : c + 2'd1;
    end
    return (c == 2'd0) ? c : c - 2'd1;
  endfunction

  task automatic model_reset();
    for (int i = 0; i < PHT_ENTRIES; i++) begin
      m_gsh[i] = 2'b10;
      m_bim[i] = 2'b10;
      m_cho[i] = 2'b10;
    end
    for (int i = 0; i < BTB_ENTRIES; i++) begin
      m_btb_valid[i] = 1'b0;
      m_btb_tag[i]   = '0;
      m_btb_tgt[i]   = '0;
    end
    m_spec   = '0;
    m_commit = '0;
  endtask

  task automatic model_predict();
    logic [12:0] b_off;
    logic [20:0] j_off;
    logic [5:0]  bi;
    logic        hit;
    logic        tourn;
    b_off = {inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    j_off = {inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    m_is_branch = (inst_i[6:0] == OP_BRANCH);
    m_imm = m_is_branch ? {{19{b_off[12]}}, b_off} : {{11{j_off[20]}}, j_off};
    m_valid = 1'b0;
    m_taken = 1'b0;
    m_pc    = pc_i + 32'd4;
    m_kind  = KIND_NONE;
    if (fetch_valid_i && !stall_i) begin
      m_valid = 1'b1;
      if (inst_i[6:0] == OP_JAL) begin
        m_taken = 1'b1;
        m_pc    = pc_i + m_imm;
        m_kind  = KIND_JUMP;
      end else if (m_is_branch) begin
        m_kind = KIND_BRANCH;
        bi     = pc_i[6:1];
        hit    = m_btb_valid[bi] && (m_btb_tag[bi] == pc_i[31:8]);
        // Choice upper bit picks gshare over bimodal
        tourn  = m_cho[pc_i[8:1]][1] ? m_gsh[pc_i[8:1] ^ m_spec][1] : m_bim[pc_i[8:1]][1];
        if (hit) begin
          m_taken = tourn;
          m_pc    = tourn ? m_btb_tgt[bi] : pc_i + 32'd4;
        end else if (m_imm[31]) begin
          m_taken = 1'b1;
          m_pc    = pc_i + m_imm;
        end
      end
    end
  endtask

  // Next state at the rising edge from the inputs of this cycle
  task automatic model_update();
    logic [7:0] gi;
    logic [7:0] bi;
    logic [1:0] g;
    logic [1:0] b;
    ghr_t       next_commit;
    if (stall_i) begin
      return;
    end
    next_commit = {m_commit[6:0], ex_taken_i};
    if (ex_valid_i) begin
      gi = ex_pc_i[8:1] ^ m_commit;
      bi = ex_pc_i[8:1];
      g  = m_gsh[gi];
      b  = m_bim[bi];
      if (g[1] != b[1]) begin
        m_cho[bi] = sat_move(m_cho[bi], g[1] == ex_taken_i);
      end
      m_gsh[gi] = sat_move(g, ex_taken_i);
      m_bim[bi] = sat_move(b, ex_taken_i);
      m_btb_valid[ex_pc_i[6:1]] = 1'b1;
      m_btb_tag[ex_pc_i[6:1]]   = ex_pc_i[31:8];
      m_btb_tgt[ex_pc_i[6:1]]   = ex_target_i;
    end
    if (ex_valid_i && ex_mispredict_i) begin
      m_spec = next_commit;
    end else if (fetch_valid_i && m_is_branch) begin
      m_spec = {m_spec[6:0], m_taken};
    end
    if (ex_valid_i) begin
      m_commit = next_commit;
    end
  endtask

  // ========================================
  // Stimulus
  // ========================================

  // Drive on the falling edge and compare a quarter period later
  task automatic drive_and_check(input logic fv, input logic st, input addr_t pc,
                                 input inst_t inst, input logic exv, input addr_t expc,
                                 input addr_t extgt, input logic ext, input logic exm);
    @(negedge clk_i);
    fetch_valid_i   = fv;
    stall_i         = st;
    pc_i            = pc;
    inst_i          = inst;
    ex_valid_i      = exv;
    ex_pc_i         = expc;
    ex_target_i     = extgt;
    ex_taken_i      = ext;
    ex_mispredict_i = exm;
    #(CLK_PERIOD / 4);
    model_predict();
    check_value("pred_valid_o", 32'(m_valid), 32'(pred_valid_o));
    check_value("pred_taken_o", 32'(m_taken), 32'(pred_taken_o));
    check_value("pred_pc_o", m_pc, pred_pc_o);
    check_value("pred_kind_o", 32'(m_kind), 32'(pred_kind_o));
  endtask

  task automatic advance_clock();
    @(posedge clk_i);
    model_update();
  endtask

  task automatic apply_reset();
    rst_ni = 1'b0;
    repeat (3) @(posedge clk_i);
    model_reset();
    @(negedge clk_i);
    rst_ni = 1'b1;
  endtask

  task automatic random_cycle();
    logic        fv;
    logic        st;
    logic        exv;
    logic        ext;
    logic        exm;
    logic [1:0]  kind;
    logic [6:0]  opc;
    logic [31:0] body;
    addr_t       pc;
    addr_t       expc;
    addr_t       extgt;
    st   = (rand_bits(3) == 0);
    fv   = (rand_bits(3) != 0);
    // Small pool of four tags over eight BTB slots
    pc   = 32'h0000_1000 | (rand_bits(2) << 8) | (rand_bits(3) << 2);
    kind = 2'(rand_bits(2));
    if (!kind[1]) begin
      opc = OP_BRANCH;
    end else if (kind[0]) begin
      opc = OP_JAL;
    end else begin
      opc = rand_bits(1) ? 7'b1100111 : 7'b0010011;
    end
    body  = rand_bits(25);
    exv   = 1'b0;
    expc  = '0;
    extgt = '0;
    ext   = 1'b0;
    exm   = 1'b0;
    if (st) begin
      // Ignored by the DUT so the queue stays untouched
      exv   = 1'(rand_bits(1));
      expc  = 32'h0000_1000 | (rand_bits(2) << 8) | (rand_bits(3) << 2);
      extgt = rand_bits(32);
      ext   = 1'(rand_bits(1));
      exm   = 1'(rand_bits(1));
    end else if (fl_pc.size() > 0 && (fl_pc.size() > 6 || rand_bits(2) != 0)) begin
      exv   = 1'b1;
      expc  = fl_pc.pop_front();
      extgt = fl_tgt.pop_front();
      ext   = 1'(rand_bits(1));
      exm   = (ext != fl_pred.pop_front());
      if (exm) begin
        mispredicts++;
      end
    end
    drive_and_check(fv, st, pc, {body[24:0], opc}, exv, expc, extgt, ext, exm);
    if (fv && !st && opc == OP_BRANCH) begin
      fl_pc.push_back(pc);
      fl_tgt.push_back(pc + m_imm);
      fl_pred.push_back(m_taken);
    end
    advance_clock();
  endtask

  // ========================================
  // Test sequence
  // ========================================

  initial begin
    rst_ni          = 1'b0;
    fetch_valid_i   = 1'b0;
    stall_i         = 1'b0;
    pc_i            = '0;
    inst_i          = '0;
    ex_valid_i      = 1'b0;
    ex_pc_i         = '0;
    ex_target_i     = '0;
    ex_taken_i      = 1'b0;
    ex_mispredict_i = 1'b0;
    lfsr_q          = 16'd95;
    check_count     = 0;
    error_count     = 0;
    test_errors     = 0;
    mispredicts     = 0;
    apply_reset();

    // JAL +0x100 followed by an ADDI
    drive_and_check(1'b1, 1'b0, 32'h2000, 32'h1000006F, 1'b0, '0, '0, 1'b0, 1'b0);
    check_value("pred_pc_o", 32'h2100, pred_pc_o);
    check_value("pred_kind_o", 32'(KIND_JUMP), 32'(pred_kind_o));
    advance_clock();
    drive_and_check(1'b1, 1'b0, 32'h2004, 32'h00100093, 1'b0, '0, '0, 1'b0, 1'b0);
    check_value("pred_taken_o", 32'd0, 32'(pred_taken_o));
    check_value("pred_pc_o", 32'h2008, pred_pc_o);
    advance_clock();
    end_test("jal_and_plain");

    // Cold BTB with offsets -16 and +8
    drive_and_check(1'b1, 1'b0, 32'h3000, 32'hFE0008E3, 1'b0, '0, '0, 1'b0, 1'b0);
    check_value("pred_pc_o", 32'h2FF0, pred_pc_o);
    advance_clock();
    drive_and_check(1'b1, 1'b0, 32'h3010, 32'h00000463, 1'b0, '0, '0, 1'b0, 1'b0);
    check_value("pred_pc_o", 32'h3014, pred_pc_o);
    advance_clock();
    end_test("static_fallback");

    // One resolution fills the slot
    drive_and_check(1'b0, 1'b0, 32'h3100, 32'h00000013, 1'b1, 32'h3100, 32'h3200, 1'b1, 1'b0);
    advance_clock();
    drive_and_check(1'b1, 1'b0, 32'h3100, 32'h00000463, 1'b0, '0, '0, 1'b0, 1'b0);
    check_value("pred_pc_o", 32'h3200, pred_pc_o);
    advance_clock();
    end_test("btb_hit");

    // A stalled resolution must not allocate
    drive_and_check(1'b1, 1'b1, 32'h3400, 32'h00000463, 1'b1, 32'h3400, 32'h3500, 1'b1, 1'b1);
    check_value("pred_valid_o", 32'd0, 32'(pred_valid_o));
    check_value("pred_pc_o", 32'h3404, pred_pc_o);
    advance_clock();
    drive_and_check(1'b1, 1'b0, 32'h3400, 32'h00000463, 1'b0, '0, '0, 1'b0, 1'b0);
    check_value("pred_pc_o", 32'h3404, pred_pc_o);
    advance_clock();
    end_test("stall_freeze");

    for (int n = 0; n < RAND_CYCLES; n++) begin
      random_cycle();
    end
    if (mispredicts == 0) begin
      error_count++;
      $display("Random traffic produced no misprediction, so history recovery was not exercised");
    end
    end_test("random_and_recovery");

    error_count += i_bp_top.i_bp_props.fail_count;
    $display("%0d checks, %0d errors, %0d mispredictions, %0d assertion failures",
             check_count, error_count, mispredicts, i_bp_top.i_bp_props.fail_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
